//--- logic/mipsCore_defs.svh
`ifndef MIPS_CORE_DEFS_SVH
`define MIPS_CORE_DEFS_SVH

// boot vector
`define RESET_PC 32'hBFC00000

`define OP_SPECIAL 6'b000000
`define OP_ADDIU 6'b001001
`define OP_ORI 6'b001101
`define OP_LUI 6'b001111
`define OP_LW 6'b100011
`define OP_SW 6'b101011
`define OP_BEQ 6'b000100
`define OP_BNE 6'b000101

// funct field of SPECIAL
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND 6'b100100
`define FN_OR 6'b100101
`define FN_SLT 6'b101010
`define FN_SLL 6'b000000

`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR 4'd3
`define ALU_SLT 4'd4
`define ALU_SLL 4'd5
`define ALU_LUI 4'd6

`define WB_ALU 2'd0
`define WB_MEM 2'd1

`define FWD_RF 2'd0
`define FWD_MEM 2'd1
`define FWD_WB 2'd2

`endif

//--- logic/mipsPkg.sv
package mipsPkg;

	// data word, byte address or instruction
	typedef logic [31:0] word_t;

	// general register number
	typedef logic [4:0] regAddr_t;

	// ALU operation code
	typedef logic [3:0] aluOp_t;

	// writeback source
	// upper immediates are built by the ALU, so they travel as ALU results
	typedef logic [1:0] wbSel_t;

	// operand taken from the register file, MEM stage or WB stage
	typedef logic [1:0] fwdSel_t;

endpackage

//--- logic/fetchStage.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module fetchStage (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic branchTaken,
	input mipsPkg::word_t branchTarget,
	input mipsPkg::word_t instr,
	output mipsPkg::word_t instrAddr,
	output mipsPkg::word_t ifIdPc,
	output mipsPkg::word_t ifIdInstr
);

	mipsPkg::word_t pc;
	mipsPkg::word_t nextPc;

	assign instrAddr = pc;

	// the delay slot is already being fetched when the branch resolves
	assign nextPc = branchTaken ? branchTarget : pc + 32'd4;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	// IF/ID register
	// an all-zero word is the nop sll $0,$0,0
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ifIdInstr <= '0;
		end else if (!stall) begin
			ifIdInstr <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifIdPc <= pc;
		end
	end

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic stall,
	input mipsPkg::word_t ifIdPc,
	input mipsPkg::word_t ifIdInstr,
	input mipsPkg::word_t rsData,
	input mipsPkg::word_t rtData,
	input mipsPkg::fwdSel_t fwdRsId,
	input mipsPkg::fwdSel_t fwdRtId,
	input mipsPkg::word_t memAluResult,
	output mipsPkg::regAddr_t rsAddr,
	output mipsPkg::regAddr_t rtAddr,
	output logic branchTaken,
	output mipsPkg::word_t branchTarget,
	output logic isBranch,
	output mipsPkg::aluOp_t exAluOp,
	output mipsPkg::wbSel_t exWbSel,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exUseImm,
	output mipsPkg::regAddr_t exRs,
	output mipsPkg::regAddr_t exRt,
	output mipsPkg::regAddr_t exRd,
	output logic [4:0] exShamt,
	output mipsPkg::word_t exRsData,
	output mipsPkg::word_t exRtData,
	output mipsPkg::word_t exImm,
	output mipsPkg::word_t exPc
);

	logic [5:0] opcode;
	logic [5:0] funct;
	mipsPkg::aluOp_t aluOp;
	mipsPkg::wbSel_t wbSel;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic useImm;
	logic zeroExt;
	logic readsRt;
	logic destIsRd;
	logic isBeq;
	logic isBne;
	mipsPkg::regAddr_t destReg;
	mipsPkg::word_t imm;
	mipsPkg::word_t rsValue;
	mipsPkg::word_t rtValue;

	assign opcode = ifIdInstr[31:26];
	assign funct = ifIdInstr[5:0];

	always_comb begin
		aluOp = `ALU_ADD;
		wbSel = `WB_ALU;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		useImm = 1'b0;
		zeroExt = 1'b0;
		readsRt = 1'b0;
		destIsRd = 1'b0;
		isBeq = 1'b0;
		isBne = 1'b0;
		case (opcode)
			`OP_SPECIAL: begin
				regWrite = 1'b1;
				readsRt = 1'b1;
				destIsRd = 1'b1;
				case (funct)
					`FN_ADDU: aluOp = `ALU_ADD;
					`FN_SUBU: aluOp = `ALU_SUB;
					`FN_AND: aluOp = `ALU_AND;
					`FN_OR: aluOp = `ALU_OR;
					`FN_SLT: aluOp = `ALU_SLT;
					`FN_SLL: aluOp = `ALU_SLL;
					default: regWrite = 1'b0;
				endcase
			end
			`OP_ADDIU: begin
				regWrite = 1'b1;
				useImm = 1'b1;
			end
			`OP_ORI: begin
				aluOp = `ALU_OR;
				regWrite = 1'b1;
				useImm = 1'b1;
				zeroExt = 1'b1;
			end
			`OP_LUI: begin
				aluOp = `ALU_LUI;
				regWrite = 1'b1;
				useImm = 1'b1;
			end
			`OP_LW: begin
				wbSel = `WB_MEM;
				regWrite = 1'b1;
				memRead = 1'b1;
				useImm = 1'b1;
			end
			`OP_SW: begin
				memWrite = 1'b1;
				useImm = 1'b1;
				readsRt = 1'b1;
			end
			`OP_BEQ: begin
				isBeq = 1'b1;
				readsRt = 1'b1;
			end
			`OP_BNE: begin
				isBne = 1'b1;
				readsRt = 1'b1;
			end
			default: ;
		endcase
	end

	// rt of an I-type ALU op is a destination, so it is not reported as a source
	assign rsAddr = ifIdInstr[25:21];
	assign rtAddr = readsRt ? ifIdInstr[20:16] : 5'd0;
	assign destReg = destIsRd ? ifIdInstr[15:11] : ifIdInstr[20:16];
	assign imm = zeroExt ? {16'b0, ifIdInstr[15:0]} : {{16{ifIdInstr[15]}}, ifIdInstr[15:0]};

	assign rsValue = (fwdRsId == `FWD_MEM) ? memAluResult : rsData;
	assign rtValue = (fwdRtId == `FWD_MEM) ? memAluResult : rtData;

	assign isBranch = isBeq || isBne;
	assign branchTaken = (isBeq && rsValue == rtValue) || (isBne && rsValue != rtValue);
	assign branchTarget = ifIdPc + 32'd4 + {imm[29:0], 2'b00};

	// a stall loads a bubble into the ID/EX register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exRs <= '0;
			exRt <= '0;
			exRd <= '0;
		end else begin
			exRegWrite <= regWrite && !stall;
			exMemRead <= memRead && !stall;
			exMemWrite <= memWrite && !stall;
			exRs <= rsAddr;
			exRt <= rtAddr;
			exRd <= destReg;
		end
	end

	always_ff @(posedge clk) begin
		exAluOp <= aluOp;
		exWbSel <= wbSel;
		exUseImm <= useImm;
		exShamt <= ifIdInstr[10:6];
		exRsData <= rsValue;
		exRtData <= rtValue;
		exImm <= imm;
		exPc <= ifIdPc;
	end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input mipsPkg::regAddr_t rsAddr,
	input mipsPkg::regAddr_t rtAddr,
	input logic wbWe,
	input mipsPkg::regAddr_t wbRd,
	input mipsPkg::word_t wbData,
	output mipsPkg::word_t rsData,
	output mipsPkg::word_t rtData
);

	mipsPkg::word_t regs [32];

	// r0 always reads zero
	// a write in the same cycle is seen by the read
	function automatic mipsPkg::word_t readPort(input mipsPkg::regAddr_t addr);
		if (addr == 5'd0) begin
			return '0;
		end else if (wbWe && wbRd == addr) begin
			return wbData;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rsData = readPort(rsAddr);
		rtData = readPort(rtAddr);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWe && wbRd != 5'd0) begin
			regs[wbRd] <= wbData;
		end
	end

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module hazardUnit (
	input mipsPkg::regAddr_t rsAddr,
	input mipsPkg::regAddr_t rtAddr,
	input logic isBranch,
	input mipsPkg::regAddr_t exRs,
	input mipsPkg::regAddr_t exRt,
	input mipsPkg::regAddr_t exRd,
	input logic exRegWrite,
	input logic exMemRead,
	input mipsPkg::regAddr_t memRd,
	input logic memRegWrite,
	input logic memMemRead,
	input mipsPkg::regAddr_t wbRd,
	input logic wbWe,
	output logic stall,
	output mipsPkg::fwdSel_t fwdRsId,
	output mipsPkg::fwdSel_t fwdRtId,
	output mipsPkg::fwdSel_t fwdRsEx,
	output mipsPkg::fwdSel_t fwdRtEx
);

	logic exHitRs;
	logic exHitRt;
	logic memLoadHit;
	logic loadUse;

	function automatic logic memWrites(input mipsPkg::regAddr_t src);
		return memRegWrite && memRd != 5'd0 && memRd == src;
	endfunction

	// newest producer wins
	function automatic mipsPkg::fwdSel_t exFwd(input mipsPkg::regAddr_t src);
		if (memWrites(src)) begin
			return `FWD_MEM;
		end else if (wbWe && wbRd == src) begin
			return `FWD_WB;
		end
		return `FWD_RF;
	endfunction

	always_comb begin
		fwdRsEx = exFwd(exRs);
		fwdRtEx = exFwd(exRt);
		// load data is not ready while the load is in MEM
		fwdRsId = (memWrites(rsAddr) && !memMemRead) ? `FWD_MEM : `FWD_RF;
		fwdRtId = (memWrites(rtAddr) && !memMemRead) ? `FWD_MEM : `FWD_RF;

		exHitRs = exRegWrite && exRd != 5'd0 && exRd == rsAddr;
		exHitRt = exRegWrite && exRd != 5'd0 && exRd == rtAddr;
		memLoadHit = memMemRead && (memWrites(rsAddr) || memWrites(rtAddr));
		loadUse = exMemRead && (exHitRs || exHitRt);
		stall = loadUse || (isBranch && (exHitRs || exHitRt || memLoadHit));
	end

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module executeStage (
	input logic clk,
	input logic rstN,
	input mipsPkg::aluOp_t exAluOp,
	input mipsPkg::wbSel_t exWbSel,
	input logic exRegWrite,
	input logic exMemRead,
	input logic exMemWrite,
	input logic exUseImm,
	input mipsPkg::regAddr_t exRd,
	input logic [4:0] exShamt,
	input mipsPkg::word_t exRsData,
	input mipsPkg::word_t exRtData,
	input mipsPkg::word_t exImm,
	input mipsPkg::word_t exPc,
	input mipsPkg::fwdSel_t fwdRsEx,
	input mipsPkg::fwdSel_t fwdRtEx,
	input mipsPkg::word_t wbData,
	output mipsPkg::word_t memAluResult,
	output mipsPkg::word_t memStoreData,
	output mipsPkg::regAddr_t memRd,
	output logic memRegWrite,
	output logic memMemRead,
	output logic memMemWrite,
	output mipsPkg::wbSel_t memWbSel,
	output mipsPkg::word_t memPc
);

	mipsPkg::word_t opA;
	mipsPkg::word_t rtValue;
	mipsPkg::word_t opB;
	mipsPkg::word_t aluResult;

	function automatic mipsPkg::word_t operandMux(
		input mipsPkg::fwdSel_t sel,
		input mipsPkg::word_t rfValue
	);
		case (sel)
			`FWD_MEM: return memAluResult;
			`FWD_WB: return wbData;
			default: return rfValue;
		endcase
	endfunction

	always_comb begin
		opA = operandMux(fwdRsEx, exRsData);
		rtValue = operandMux(fwdRtEx, exRtData);
		opB = exUseImm ? exImm : rtValue;
		case (exAluOp)
			`ALU_SUB: aluResult = opA - opB;
			`ALU_AND: aluResult = opA & opB;
			`ALU_OR: aluResult = opA | opB;
			`ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(opB)};
			`ALU_SLL: aluResult = opB << exShamt;
			`ALU_LUI: aluResult = {opB[15:0], 16'b0};
			default: aluResult = opA + opB;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memRegWrite <= 1'b0;
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
			memRd <= '0;
		end else begin
			memRegWrite <= exRegWrite;
			memMemRead <= exMemRead;
			memMemWrite <= exMemWrite;
			memRd <= exRd;
		end
	end

	always_ff @(posedge clk) begin
		memAluResult <= aluResult;
		memStoreData <= rtValue;
		memWbSel <= exWbSel;
		memPc <= exPc;
	end

endmodule

//--- logic/memWbStage.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module memWbStage (
	input logic clk,
	input logic rstN,
	input mipsPkg::word_t memAluResult,
	input mipsPkg::word_t memStoreData,
	input mipsPkg::regAddr_t memRd,
	input logic memRegWrite,
	input logic memMemWrite,
	input mipsPkg::wbSel_t memWbSel,
	input mipsPkg::word_t memPc,
	input mipsPkg::word_t dataRdata,
	output mipsPkg::word_t dataAddr,
	output logic dataWe,
	output mipsPkg::word_t dataWdata,
	output logic wbWe,
	output mipsPkg::regAddr_t wbRd,
	output mipsPkg::word_t wbData,
	output mipsPkg::word_t debugWbPc,
	output logic debugWbRfWen,
	output mipsPkg::regAddr_t debugWbRfWnum,
	output mipsPkg::word_t debugWbRfWdata
);

	mipsPkg::word_t memResult;
	mipsPkg::word_t wbPc;

	// data memory answers in the same cycle
	assign dataAddr = memAluResult;
	assign dataWe = memMemWrite;
	assign dataWdata = memStoreData;
	assign memResult = (memWbSel == `WB_MEM) ? dataRdata : memAluResult;

	// writes to r0 are dropped at the MEM/WB register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbWe <= 1'b0;
			wbRd <= '0;
		end else begin
			wbWe <= memRegWrite && memRd != 5'd0;
			wbRd <= memRd;
		end
	end

	always_ff @(posedge clk) begin
		wbData <= memResult;
		wbPc <= memPc;
	end

	assign debugWbPc = wbPc;
	assign debugWbRfWen = wbWe;
	assign debugWbRfWnum = wbRd;
	assign debugWbRfWdata = wbData;

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
	input logic clk,
	input logic rstN,
	output mipsPkg::word_t instrAddr,
	input mipsPkg::word_t instr,
	output mipsPkg::word_t dataAddr,
	output logic dataWe,
	output mipsPkg::word_t dataWdata,
	input mipsPkg::word_t dataRdata,
	output mipsPkg::word_t debugWbPc,
	output logic debugWbRfWen,
	output mipsPkg::regAddr_t debugWbRfWnum,
	output mipsPkg::word_t debugWbRfWdata
);

	logic stall;
	logic branchTaken;
	logic isBranch;
	mipsPkg::word_t branchTarget;
	mipsPkg::word_t ifIdPc;
	mipsPkg::word_t ifIdInstr;

	mipsPkg::regAddr_t rsAddr;
	mipsPkg::regAddr_t rtAddr;
	mipsPkg::word_t rsData;
	mipsPkg::word_t rtData;
	mipsPkg::fwdSel_t fwdRsId;
	mipsPkg::fwdSel_t fwdRtId;
	mipsPkg::fwdSel_t fwdRsEx;
	mipsPkg::fwdSel_t fwdRtEx;

	// ID/EX
	mipsPkg::aluOp_t exAluOp;
	mipsPkg::wbSel_t exWbSel;
	logic exRegWrite;
	logic exMemRead;
	logic exMemWrite;
	logic exUseImm;
	mipsPkg::regAddr_t exRs;
	mipsPkg::regAddr_t exRt;
	mipsPkg::regAddr_t exRd;
	logic [4:0] exShamt;
	mipsPkg::word_t exRsData;
	mipsPkg::word_t exRtData;
	mipsPkg::word_t exImm;
	mipsPkg::word_t exPc;

	// EX/MEM
	mipsPkg::word_t memAluResult;
	mipsPkg::word_t memStoreData;
	mipsPkg::regAddr_t memRd;
	logic memRegWrite;
	logic memMemRead;
	logic memMemWrite;
	mipsPkg::wbSel_t memWbSel;
	mipsPkg::word_t memPc;

	// WB write port
	logic wbWe;
	mipsPkg::regAddr_t wbRd;
	mipsPkg::word_t wbData;

	fetchStage i_fetchStage (
		.clk(clk), .rstN(rstN), .stall(stall),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .instr(instr),
		.instrAddr(instrAddr), .ifIdPc(ifIdPc), .ifIdInstr(ifIdInstr)
	);

	decodeStage i_decodeStage (
		.clk(clk), .rstN(rstN), .stall(stall),
		.ifIdPc(ifIdPc), .ifIdInstr(ifIdInstr),
		.rsData(rsData), .rtData(rtData),
		.fwdRsId(fwdRsId), .fwdRtId(fwdRtId), .memAluResult(memAluResult),
		.rsAddr(rsAddr), .rtAddr(rtAddr),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .isBranch(isBranch),
		.exAluOp(exAluOp), .exWbSel(exWbSel),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.exMemWrite(exMemWrite), .exUseImm(exUseImm),
		.exRs(exRs), .exRt(exRt), .exRd(exRd), .exShamt(exShamt),
		.exRsData(exRsData), .exRtData(exRtData), .exImm(exImm), .exPc(exPc)
	);

	regFile i_regFile (
		.clk(clk), .rstN(rstN),
		.rsAddr(rsAddr), .rtAddr(rtAddr),
		.wbWe(wbWe), .wbRd(wbRd), .wbData(wbData),
		.rsData(rsData), .rtData(rtData)
	);

	hazardUnit i_hazardUnit (
		.rsAddr(rsAddr), .rtAddr(rtAddr), .isBranch(isBranch),
		.exRs(exRs), .exRt(exRt), .exRd(exRd),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.memRd(memRd), .memRegWrite(memRegWrite), .memMemRead(memMemRead),
		.wbRd(wbRd), .wbWe(wbWe),
		.stall(stall), .fwdRsId(fwdRsId), .fwdRtId(fwdRtId),
		.fwdRsEx(fwdRsEx), .fwdRtEx(fwdRtEx)
	);

	executeStage i_executeStage (
		.clk(clk), .rstN(rstN),
		.exAluOp(exAluOp), .exWbSel(exWbSel),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.exMemWrite(exMemWrite), .exUseImm(exUseImm),
		.exRd(exRd), .exShamt(exShamt),
		.exRsData(exRsData), .exRtData(exRtData), .exImm(exImm), .exPc(exPc),
		.fwdRsEx(fwdRsEx), .fwdRtEx(fwdRtEx), .wbData(wbData),
		.memAluResult(memAluResult), .memStoreData(memStoreData), .memRd(memRd),
		.memRegWrite(memRegWrite), .memMemRead(memMemRead),
		.memMemWrite(memMemWrite), .memWbSel(memWbSel), .memPc(memPc)
	);

	memWbStage i_memWbStage (
		.clk(clk), .rstN(rstN),
		.memAluResult(memAluResult), .memStoreData(memStoreData), .memRd(memRd),
		.memRegWrite(memRegWrite), .memMemWrite(memMemWrite),
		.memWbSel(memWbSel), .memPc(memPc), .dataRdata(dataRdata),
		.dataAddr(dataAddr), .dataWe(dataWe), .dataWdata(dataWdata),
		.wbWe(wbWe), .wbRd(wbRd), .wbData(wbData),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

endmodule

//--- testbench/mipsCoreTb.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module mipsCoreTb;

	// about 70 instructions with a few stalls, plus pipeline fill and drain
	localparam int MaxCycles = 400;

	logic clk;
	logic rstN;
	mipsPkg::word_t instrAddr;
	mipsPkg::word_t instr;
	mipsPkg::word_t dataAddr;
	logic dataWe;
	mipsPkg::word_t dataWdata;
	mipsPkg::word_t dataRdata;
	mipsPkg::word_t debugWbPc;
	logic debugWbRfWen;
	mipsPkg::regAddr_t debugWbRfWnum;
	mipsPkg::word_t debugWbRfWdata;

	mipsPkg::word_t imem [256];
	mipsPkg::word_t dmem [256];
	string testOf [256];
	string section;
	int progLen = 0;
	int endIdx = 0;
	integer seed;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic timedOut = 1'b0;
	logic afterReset = 1'b0;

	// expected register writes and stores, in program order
	mipsPkg::word_t expPc [$];
	mipsPkg::regAddr_t expReg [$];
	mipsPkg::word_t expVal [$];
	string expName [$];
	mipsPkg::word_t expStAddr [$];
	mipsPkg::word_t expStData [$];
	string expStName [$];

	mipsCore i_mipsCore (
		.clk(clk), .rstN(rstN),
		.instrAddr(instrAddr), .instr(instr),
		.dataAddr(dataAddr), .dataWe(dataWe), .dataWdata(dataWdata), .dataRdata(dataRdata),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	// both memories answer in the same cycle
	assign instr = imem[instrAddr[9:2]];
	assign dataRdata = dmem[dataAddr[9:2]];

	always @(posedge clk) begin
		if (dataWe) begin
			dmem[dataAddr[9:2]] <= dataWdata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	function automatic mipsPkg::word_t fillWord(input int idx);
		return 32'h5A5A0000 ^ (32'(idx) * 32'h9E3779B1);
	endfunction

	function automatic mipsPkg::word_t rType(input logic [5:0] fn, input mipsPkg::regAddr_t rs,
		input mipsPkg::regAddr_t rt, input mipsPkg::regAddr_t rd, input logic [4:0] sa);
		return {`OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic mipsPkg::word_t iType(input logic [5:0] op, input mipsPkg::regAddr_t rs,
		input mipsPkg::regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input mipsPkg::word_t w);
		imem[progLen] = w;
		testOf[progLen] = section;
		progLen++;
	endtask

	task automatic assemble();
		mipsPkg::regAddr_t prev;
		mipsPkg::regAddr_t dest;
		mipsPkg::regAddr_t other;
		logic [15:0] imm;
		logic [15:0] offA;
		logic [15:0] offB;
		logic [15:0] offC;
		section = "alu-forwarding";
		emit(iType(`OP_LUI, 5'd0, 5'd2, 16'($random(seed))));
		emit(iType(`OP_ORI, 5'd2, 5'd2, 16'($random(seed))));
		emit(iType(`OP_ADDIU, 5'd2, 5'd3, 16'($random(seed))));
		// r0 must never show up at the debug port
		emit(rType(`FN_ADDU, 5'd2, 5'd3, 5'd0, 5'd0));
		prev = 5'd3;
		// each op reads the result of the one before it
		// and every op type comes up at least twice
		for (int k = 0; k < 24; k++) begin
			dest = 5'(2 + $unsigned($random(seed)) % 12);
			other = 5'(2 + $unsigned($random(seed)) % 12);
			imm = 16'($random(seed));
			case (k % 9)
				0: emit(rType(`FN_ADDU, prev, other, dest, 5'd0));
				1: emit(rType(`FN_SUBU, prev, other, dest, 5'd0));
				2: emit(rType(`FN_AND, other, prev, dest, 5'd0));
				3: emit(rType(`FN_OR, prev, other, dest, 5'd0));
				4: emit(rType(`FN_SLT, prev, other, dest, 5'd0));
				5: emit(rType(`FN_SLL, 5'd0, prev, dest, imm[4:0]));
				6: emit(iType(`OP_ADDIU, prev, dest, imm));
				7: emit(iType(`OP_ORI, prev, dest, imm));
				default: emit(iType(`OP_LUI, 5'd0, dest, imm));
			endcase
			prev = dest;
		end

		section = "load-use";
		offA = 16'(($unsigned($random(seed)) % 64) * 4);
		offB = offA + 16'h0100;
		offC = offA + 16'h0200;
		emit(iType(`OP_ORI, 5'd0, 5'd1, 16'h0100));
		emit(iType(`OP_LW, 5'd1, 5'd14, offA));
		emit(rType(`FN_ADDU, 5'd14, 5'd2, 5'd15, 5'd0));
		emit(iType(`OP_LW, 5'd1, 5'd16, offB));
		emit(rType(`FN_SLL, 5'd0, 5'd16, 5'd17, 5'd3));
		emit(iType(`OP_LW, 5'd1, 5'd18, offC));
		emit(iType(`OP_ADDIU, 5'd18, 5'd19, 16'($random(seed))));

		section = "store-load";
		emit(iType(`OP_SW, 5'd1, 5'd15, offA));
		emit(rType(`FN_OR, 5'd17, 5'd19, 5'd20, 5'd0));
		emit(iType(`OP_SW, 5'd1, 5'd20, offB));
		emit(iType(`OP_LW, 5'd1, 5'd21, offA));
		emit(iType(`OP_LW, 5'd1, 5'd22, offB));
		emit(rType(`FN_SUBU, 5'd21, 5'd22, 5'd23, 5'd0));
		emit(iType(`OP_SW, 5'd1, 5'd23, offC));
		emit(iType(`OP_LW, 5'd1, 5'd24, offC));

		section = "branch";
		// taken branch on a result of the instruction just before
		emit(iType(`OP_ADDIU, 5'd2, 5'd25, 16'h0000));
		emit(iType(`OP_BEQ, 5'd25, 5'd2, 16'd2));
		emit(iType(`OP_ADDIU, 5'd0, 5'd26, 16'($random(seed))));
		emit(iType(`OP_ADDIU, 5'd0, 5'd27, 16'($random(seed))));
		// not taken
		emit(iType(`OP_BNE, 5'd25, 5'd2, 16'd2));
		emit(iType(`OP_ADDIU, 5'd26, 5'd26, 16'($random(seed))));
		emit(iType(`OP_ADDIU, 5'd0, 5'd27, 16'($random(seed))));
		// r28 sits in MEM when the branch decodes
		emit(iType(`OP_ORI, 5'd0, 5'd28, 16'h0007));
		emit(iType(`OP_ADDIU, 5'd0, 5'd29, 16'h0001));
		emit(iType(`OP_BNE, 5'd28, 5'd0, 16'd3));
		emit(rType(`FN_ADDU, 5'd29, 5'd28, 5'd29, 5'd0));
		emit(iType(`OP_ADDIU, 5'd0, 5'd28, 16'($random(seed))));
		emit(iType(`OP_ADDIU, 5'd0, 5'd29, 16'($random(seed))));
		emit(rType(`FN_SUBU, 5'd28, 5'd29, 5'd30, 5'd0));
		emit(iType(`OP_BEQ, 5'd30, 5'd0, 16'd2));
		emit(rType(`FN_SLL, 5'd0, 5'd30, 5'd30, 5'd2));
		emit(iType(`OP_ADDIU, 5'd0, 5'd31, 16'($random(seed))));
		// load in EX, then in MEM
		emit(iType(`OP_LW, 5'd1, 5'd30, offA));
		emit(iType(`OP_BEQ, 5'd30, 5'd21, 16'd2));
		emit(iType(`OP_ADDIU, 5'd30, 5'd31, 16'($random(seed))));
		emit(iType(`OP_ORI, 5'd0, 5'd31, 16'($random(seed))));
		emit(iType(`OP_LW, 5'd1, 5'd27, offB));
		emit(iType(`OP_ADDIU, 5'd0, 5'd26, 16'h0001));
		emit(iType(`OP_BNE, 5'd27, 5'd22, 16'd2));
		emit(iType(`OP_ADDIU, 5'd27, 5'd25, 16'($random(seed))));
		emit(rType(`FN_AND, 5'd25, 5'd27, 5'd24, 5'd0));

		// spin on a self loop with a nop in the delay slot
		section = "end";
		endIdx = progLen;
		emit(iType(`OP_BEQ, 5'd0, 5'd0, 16'hFFFF));
		emit(32'h0);
	endtask

	// sequential reference of the instruction set, with delay slots
	task automatic runModel();
		mipsPkg::word_t regs [32];
		mipsPkg::word_t mem [256];
		mipsPkg::word_t ins;
		mipsPkg::word_t a;
		mipsPkg::word_t b;
		mipsPkg::word_t simm;
		mipsPkg::word_t addr;
		mipsPkg::word_t result;
		mipsPkg::regAddr_t dest;
		logic writes;
		int curPc;
		int pc;
		int nextPc;
		int target;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = fillWord(i);
		end
		pc = 0;
		nextPc = 1;
		curPc = -1;
		steps = 0;
		while (curPc != endIdx && steps < 300) begin
			curPc = pc;
			ins = imem[curPc];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			addr = a + simm;
			writes = 1'b1;
			dest = ins[20:16];
			result = '0;
			target = nextPc + 1;
			case (ins[31:26])
				`OP_SPECIAL: begin
					dest = ins[15:11];
					case (ins[5:0])
						`FN_ADDU: result = a + b;
						`FN_SUBU: result = a - b;
						`FN_AND: result = a & b;
						`FN_OR: result = a | b;
						`FN_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						`FN_SLL: result = b << ins[10:6];
						default: writes = 1'b0;
					endcase
				end
				`OP_ADDIU: result = a + simm;
				`OP_ORI: result = a | {16'b0, ins[15:0]};
				`OP_LUI: result = {ins[15:0], 16'b0};
				`OP_LW: result = mem[addr[9:2]];
				`OP_SW: begin
					writes = 1'b0;
					mem[addr[9:2]] = b;
					expStAddr.push_back(addr);
					expStData.push_back(b);
					expStName.push_back(testOf[curPc]);
				end
				`OP_BEQ, `OP_BNE: begin
					writes = 1'b0;
					if ((a == b) == (ins[31:26] == `OP_BEQ)) begin
						target = curPc + 1 + int'($signed(ins[15:0]));
					end
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest != 5'd0) begin
				regs[dest] = result;
				expPc.push_back(`RESET_PC + 32'(curPc * 4));
				expReg.push_back(dest);
				expVal.push_back(result);
				expName.push_back(testOf[curPc]);
			end
			pc = nextPc;
			nextPc = target;
			steps++;
		end
	endtask

	task automatic reportMismatch(input string name, input string what,
		input mipsPkg::word_t expected, input mipsPkg::word_t actual);
		errors++;
		$display("FAIL %s %s: expected %h, actual %h", name, what, expected, actual);
	endtask

	task automatic checkWrite();
		if (expPc.size() == 0) begin
			errors++;
			$display("register write at pc %h was not expected", debugWbPc);
		end else begin
			checks++;
			assert (debugWbPc == expPc[0])
				else reportMismatch(expName[0], "pc", expPc[0], debugWbPc);
			assert (debugWbRfWnum == expReg[0])
				else reportMismatch(expName[0], "reg", 32'(expReg[0]), 32'(debugWbRfWnum));
			assert (debugWbRfWdata == expVal[0])
				else reportMismatch(expName[0], "data", expVal[0], debugWbRfWdata);
			void'(expPc.pop_front());
			void'(expReg.pop_front());
			void'(expVal.pop_front());
			void'(expName.pop_front());
		end
	endtask

	task automatic checkStore();
		if (expStAddr.size() == 0) begin
			errors++;
			$display("store to %h was not expected", dataAddr);
		end else begin
			checks++;
			assert (dataAddr == expStAddr[0])
				else reportMismatch(expStName[0], "store address", expStAddr[0], dataAddr);
			assert (dataWdata == expStData[0])
				else reportMismatch(expStName[0], "store data", expStData[0], dataWdata);
			void'(expStAddr.pop_front());
			void'(expStData.pop_front());
			void'(expStName.pop_front());
		end
	endtask

	// outputs are sampled on the falling edge once they have settled
	always @(negedge clk) begin
		if (!rstN) begin
			assert (!debugWbRfWen && !dataWe) else begin
				errors++;
				$display("a write strobe was high during reset");
			end
			afterReset = 1'b1;
		end else begin
			if (afterReset) begin
				assert (instrAddr == `RESET_PC)
					else reportMismatch("reset", "first instrAddr", `RESET_PC, instrAddr);
				afterReset = 1'b0;
			end
			if (debugWbRfWen) begin
				checkWrite();
			end
			if (dataWe) begin
				checkStore();
			end
		end
	end

	initial begin
		rstN = 1'b0;
		seed = 32'h3562;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] <= fillWord(i);
		end
		assemble();
		runModel();
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		while ((expPc.size() != 0 || expStAddr.size() != 0) && cycles < MaxCycles) begin
			@(posedge clk);
		end
		timedOut = (cycles >= MaxCycles);
		if (timedOut) begin
			$display("timeout: the program did not finish within %0d cycles", MaxCycles);
		end else begin
			// anything written after the last expected write is caught here
			repeat (8) @(posedge clk);
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timedOut);
		if (errors == 0 && !timedOut) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+logic
logic/mipsPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/mipsCore.sv
testbench/mipsCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mipsCore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module mipsCoreTb -o mipsCoreSim

./obj_dir/mipsCoreSim | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
